//--- sim.f
lcd_pkg.sv
init_rom.sv
init_sequencer.sv
pixel_streamer.sv
bus_arbiter.sv
spi_byte_tx.sv
st7735_top.sv
tb_st7735.sv

//--- Bender.yml
package:
  name: st7735_driver

sources:
  - lcd_pkg.sv
  - init_rom.sv
  - init_sequencer.sv
  - pixel_streamer.sv
  - bus_arbiter.sv
  - spi_byte_tx.sv
  - st7735_top.sv
  - target: simulation
    files:
      - tb_st7735.sv

//--- tb_st7735.sv
`timescale 1ns/1ps
`default_nettype none

module tb_st7735;
    import lcd_pkg::*;

    localparam int PANEL_W     = 4;
    localparam int PANEL_H     = 3;
    localparam int WAKE_DELAY  = 20;
    localparam int CLK_HALF    = 4;
    localparam int SEED        = 69074;
    localparam int WAIT_LIMIT  = 2000;
    // RAMWR plus two bytes per pixel
    localparam int FRAME_LEN   = 1 + 2 * PANEL_W * PANEL_H;

    logic   LCD_CLK = 1'b1;
    logic   arst_n;
    pixel_t fill_color;
    logic   cs;
    logic   sck;
    logic   mosi;
    logic   dc;
    logic   lcd_rst;

    // link decoder state
    byte_t  rx_shift;
    logic   rx_dc;
    int     rx_edges = 0;
    byte_t  rec_byte[$];
    logic   rec_dc[$];

    // expected init bytes
    byte_t  exp_byte[$];
    logic   exp_dc[$];

    int     errors = 0;
    int     frame_errs = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     errs_at_start;
    int     base;
    pixel_t color_a;
    pixel_t color_b;

    st7735_top #(
        .WIDTH       (PANEL_W),
        .HEIGHT      (PANEL_H),
        .DELAY_CYCLES(WAKE_DELAY)
    ) UUT (
        .LCD_CLK   (LCD_CLK),
        .arst_n    (arst_n),
        .fill_color(fill_color),
        .cs        (cs),
        .sck       (sck),
        .mosi      (mosi),
        .dc        (dc),
        .lcd_rst   (lcd_rst)
    );

    always #CLK_HALF LCD_CLK = ~LCD_CLK;

    // panel samples on the rising sck edge
    always @(posedge sck) begin
        if (arst_n && !cs) begin
            rx_shift = {rx_shift[6:0], mosi};
            rx_dc    = dc;
            rx_edges = rx_edges + 1;
        end
    end

    // a byte ends when cs rises, a reset just drops the partial byte
    always @(posedge cs) begin
        if (arst_n) begin
            assert (rx_edges == 8)
            else begin
                $display("Error at %0d ns: cs window held %0d sck edges instead of 8",
                         $time, rx_edges);
                errors     = errors + 1;
                frame_errs = frame_errs + 1;
            end
            rec_byte.push_back(rx_shift);
            rec_dc.push_back(rx_dc);
        end
        rx_edges = 0;
    end

    // link stays idle while the panel is in reset
    idle_in_reset: assert property (@(posedge LCD_CLK) !lcd_rst |-> (cs && sck))
    else begin
        $display("Error at %0d ns: link active while lcd_rst low, cs %b sck %b",
                 $time, cs, sck);
        errors = errors + 1;
    end

    dc_steady: assert property (@(posedge LCD_CLK) disable iff (!arst_n)
        !cs |=> (cs || $stable(dc)))
    else begin
        $display("Error at %0d ns: dc changed inside a byte", $time);
        errors     = errors + 1;
        frame_errs = frame_errs + 1;
    end

    task automatic add_expect(input byte_t b, input logic d);
        exp_byte.push_back(b);
        exp_dc.push_back(d);
    endtask

    // init bytes in panel order, WAIT entries send nothing
    task automatic build_init_table();
        add_expect(8'h11, 1'b0);
        add_expect(8'h3A, 1'b0);
        add_expect(8'h05, 1'b1);
        add_expect(8'h36, 1'b0);
        add_expect(8'h00, 1'b1);
        add_expect(8'h21, 1'b0);
        add_expect(8'h2A, 1'b0);
        add_expect(8'h00, 1'b1);
        add_expect(8'h00, 1'b1);
        add_expect(8'h00, 1'b1);
        add_expect(8'h03, 1'b1);
        add_expect(8'h2B, 1'b0);
        add_expect(8'h00, 1'b1);
        add_expect(8'h00, 1'b1);
        add_expect(8'h00, 1'b1);
        add_expect(8'h02, 1'b1);
        add_expect(8'h29, 1'b0);
    endtask

    task automatic check_byte(input int idx, input byte_t exp_b, input logic exp_d,
                              input string what);
        assert (rec_byte[idx] === exp_b && rec_dc[idx] === exp_d)
        else begin
            $display("Error at %0d ns: %s, byte %0d is %02h dc %0b, expected %02h dc %0b",
                     $time, what, idx, rec_byte[idx], rec_dc[idx], exp_b, exp_d);
            errors = errors + 1;
        end
    endtask

    task automatic check_init(input int first);
        for (int i = 0; i < exp_byte.size(); i++) begin
            check_byte(first + i, exp_byte[i], exp_dc[i], "init table");
        end
    endtask

    task automatic check_frame(input int first, input pixel_t color);
        check_byte(first, 8'h2C, 1'b0, "frame command");
        for (int p = 0; p < PANEL_W * PANEL_H; p++) begin
            check_byte(first + 1 + 2 * p, color[15:8], 1'b1, "pixel high byte");
            check_byte(first + 2 + 2 * p, color[7:0], 1'b1, "pixel low byte");
        end
    endtask

    task automatic check_reset_levels();
        assert (cs === 1'b1 && sck === 1'b1 && dc === 1'b1 && mosi === 1'b0 &&
                lcd_rst === 1'b0)
        else begin
            $display("Error at %0d ns: reset levels cs %b sck %b dc %b mosi %b lcd_rst %b",
                     $time, cs, sck, dc, mosi, lcd_rst);
            errors = errors + 1;
        end
    endtask

    // called 1 ns after a rising edge, releases 1 ns after the third one
    task automatic apply_reset();
        arst_n = 1'b0;
        #1;
        check_reset_levels();
        repeat (3) @(posedge LCD_CLK);
        #1;
        check_reset_levels();
        arst_n = 1'b1;
    endtask

    task automatic wait_for_bytes(input int count);
        int cycles;
        cycles = 0;
        while (rec_byte.size() < count && cycles < WAIT_LIMIT) begin
            @(posedge LCD_CLK);
            #1;
            cycles = cycles + 1;
        end
        if (rec_byte.size() < count) begin
            $display("Timeout: only %0d of %0d bytes seen on the link after %0d cycles",
                     rec_byte.size(), count, WAIT_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    task automatic wait_for_panel_wake();
        int cycles;
        cycles = 0;
        while (lcd_rst !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge LCD_CLK);
            #1;
            cycles = cycles + 1;
        end
        if (lcd_rst !== 1'b1) begin
            $display("Timeout: lcd_rst never went high within %0d cycles", WAIT_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    task automatic report_test(input int num, input string name, input logic bad);
        tests_run = tests_run + 1;
        if (bad) begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: failed", num, name);
        end else begin
            $display("test %0d %s: ok", num, name);
        end
    endtask

    initial begin
        arst_n     = 1'b1;
        fill_color = '0;
        void'($urandom(SEED));
        color_a    = pixel_t'($urandom());
        // distinct halves so a swapped byte order shows up
        while (color_a[15:8] == color_a[7:0]) begin
            color_a = pixel_t'($urandom());
        end
        color_b    = pixel_t'($urandom());
        while (color_b == color_a || color_b[15:8] == color_b[7:0]) begin
            color_b = pixel_t'($urandom());
        end
        build_init_table();
        fill_color = color_a;

        #1;
        errs_at_start = errors;
        apply_reset();
        wait_for_panel_wake();
        assert (rec_byte.size() == 0 && cs === 1'b1)
        else begin
            $display("Error at %0d ns: link was used before lcd_rst went high", $time);
            errors = errors + 1;
        end
        report_test(1, "reset and idle levels", errors != errs_at_start);

        errs_at_start = errors;
        wait_for_bytes(exp_byte.size());
        check_init(0);
        report_test(3, "init order", errors != errs_at_start);

        errs_at_start = errors;
        base = exp_byte.size();
        wait_for_bytes(base + FRAME_LEN);
        check_frame(base, color_a);
        report_test(4, "first frame", errors != errs_at_start);
        report_test(2, "byte framing", frame_errs != 0);

        // new colour a few pixels into the second frame
        errs_at_start = errors;
        base = base + FRAME_LEN;
        wait_for_bytes(base + 7);
        fill_color = color_b;
        wait_for_bytes(base + 2 * FRAME_LEN);
        check_frame(base, color_a);
        check_frame(base + FRAME_LEN, color_b);
        report_test(5, "frame repeat and colour latch", errors != errs_at_start);

        errs_at_start = errors;
        wait_for_bytes(base + 2 * FRAME_LEN + 5);
        apply_reset();
        base = rec_byte.size();
        wait_for_panel_wake();
        assert (rec_byte.size() == base)
        else begin
            $display("Error at %0d ns: bytes sent while the panel was in reset", $time);
            errors = errors + 1;
        end
        wait_for_bytes(base + exp_byte.size());
        check_init(base);
        report_test(6, "reset mid-stream", errors != errs_at_start);

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- st7735_top.sv
`timescale 1ns/1ps
`default_nettype none

module st7735_top #(
    parameter int WIDTH        = lcd_pkg::DEFAULT_WIDTH,
    parameter int HEIGHT       = lcd_pkg::DEFAULT_HEIGHT,
    parameter int DELAY_CYCLES = lcd_pkg::DEFAULT_DELAY_CYCLES
) (
    input  logic            LCD_CLK,
    input  logic            arst_n,
    input  lcd_pkg::pixel_t fill_color,
    output logic            cs,
    output logic            sck,
    output logic            mosi,
    output logic            dc,
    output logic            lcd_rst
);
    import lcd_pkg::*;

    logic  init_req, init_grant, init_done, init_dc, init_start;
    logic  frame_req, frame_grant, frame_done, frame_dc, frame_start;
    logic  tx_busy, tx_done, tx_dc, tx_start;
    byte_t init_byte, frame_byte, tx_byte;

    init_sequencer #(
        .WIDTH       (WIDTH),
        .HEIGHT      (HEIGHT),
        .DELAY_CYCLES(DELAY_CYCLES)
    ) u_init (
        .LCD_CLK(LCD_CLK), .arst_n(arst_n), .grant(init_grant), .done(init_done),
        .req(init_req), .byte_out(init_byte), .dc(init_dc), .start(init_start),
        .lcd_rst(lcd_rst)
    );

    pixel_streamer #(
        .WIDTH (WIDTH),
        .HEIGHT(HEIGHT)
    ) u_pixels (
        .LCD_CLK(LCD_CLK), .arst_n(arst_n), .grant(frame_grant), .done(frame_done),
        .fill_color(fill_color), .req(frame_req), .byte_out(frame_byte), .dc(frame_dc),
        .start(frame_start)
    );

    bus_arbiter u_arb (
        .LCD_CLK(LCD_CLK), .arst_n(arst_n), .init_req(init_req), .frame_req(frame_req),
        .init_byte(init_byte), .init_dc(init_dc), .init_start(init_start),
        .frame_byte(frame_byte), .frame_dc(frame_dc), .frame_start(frame_start),
        .tx_busy(tx_busy), .tx_done(tx_done), .init_grant(init_grant),
        .frame_grant(frame_grant), .init_done(init_done), .frame_done(frame_done),
        .tx_byte(tx_byte), .tx_dc(tx_dc), .tx_start(tx_start)
    );

    spi_byte_tx u_tx (
        .LCD_CLK(LCD_CLK), .arst_n(arst_n), .start(tx_start), .byte_in(tx_byte),
        .dc_in(tx_dc), .busy(tx_busy), .done(tx_done), .cs(cs), .sck(sck), .mosi(mosi),
        .dc(dc)
    );

endmodule

`default_nettype wire

//--- spi_byte_tx.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_tx (
    input  logic           LCD_CLK,
    input  logic           arst_n,
    input  logic           start,
    input  lcd_pkg::byte_t byte_in,
    input  logic           dc_in,
    output logic           busy,
    output logic           done,
    output logic           cs,
    output logic           sck,
    output logic           mosi,
    output logic           dc
);
    import lcd_pkg::*;

    localparam int PH_W = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;

    byte_t           shift_q;
    logic [2:0]      bit_cnt;
    logic [PH_W-1:0] phase;
    logic            last_phase;
    logic            rise_phase;

    assign last_phase = (phase == PH_W'(BIT_CYCLES - 1));
    assign rise_phase = (phase == PH_W'(BIT_CYCLES / 2 - 1));

    always_ff @(posedge LCD_CLK or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            cs      <= 1'b1;
            sck     <= 1'b1;
            mosi    <= 1'b0;
            dc      <= 1'b1;
            bit_cnt <= '0;
            phase   <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy    <= 1'b1;
                    cs      <= 1'b0;
                    sck     <= 1'b0;
                    mosi    <= byte_in[7];
                    dc      <= dc_in;
                    bit_cnt <= '0;
                    phase   <= '0;
                end
            end else if (last_phase) begin
                phase <= '0;
                // panel has sampled the last bit, close the frame
                if (bit_cnt == 3'd7) begin
                    busy <= 1'b0;
                    cs   <= 1'b1;
                    sck  <= 1'b1;
                    done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    sck     <= 1'b0;
                    mosi    <= shift_q[6];
                end
            end else begin
                phase <= phase + 1'b1;
                if (rise_phase) begin
                    sck <= 1'b1;
                end
            end
        end
    end

    // msb first
    always_ff @(posedge LCD_CLK) begin
        if (!busy && start) begin
            shift_q <= byte_in;
        end else if (busy && last_phase) begin
            shift_q <= shift_q << 1;
        end
    end

endmodule

`default_nettype wire

//--- bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic           LCD_CLK,
    input  logic           arst_n,
    input  logic           init_req,
    input  logic           frame_req,
    input  lcd_pkg::byte_t init_byte,
    input  logic           init_dc,
    input  logic           init_start,
    input  lcd_pkg::byte_t frame_byte,
    input  logic           frame_dc,
    input  logic           frame_start,
    input  logic           tx_busy,
    input  logic           tx_done,
    output logic           init_grant,
    output logic           frame_grant,
    output logic           init_done,
    output logic           frame_done,
    output lcd_pkg::byte_t tx_byte,
    output logic           tx_dc,
    output logic           tx_start
);

    // init wins, ownership only moves between bytes
    always_ff @(posedge LCD_CLK or negedge arst_n) begin
        if (!arst_n) begin
            init_grant  <= 1'b0;
            frame_grant <= 1'b0;
        end else if (!tx_busy) begin
            init_grant  <= init_req;
            frame_grant <= frame_req && !init_req;
        end
    end

    assign tx_byte  = frame_grant ? frame_byte : init_byte;
    assign tx_dc    = frame_grant ? frame_dc : init_dc;
    assign tx_start = (init_grant && init_start) || (frame_grant && frame_start);

    assign init_done  = init_grant && tx_done;
    assign frame_done = frame_grant && tx_done;

endmodule

`default_nettype wire

//--- pixel_streamer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_streamer #(
    parameter int WIDTH  = lcd_pkg::DEFAULT_WIDTH,
    parameter int HEIGHT = lcd_pkg::DEFAULT_HEIGHT
) (
    input  logic            LCD_CLK,
    input  logic            arst_n,
    input  logic            grant,
    input  logic            done,
    input  lcd_pkg::pixel_t fill_color,
    output logic            req,
    output lcd_pkg::byte_t  byte_out,
    output logic            dc,
    output logic            start
);
    import lcd_pkg::*;

    typedef enum logic [1:0] {
        ST_CMD,
        ST_CMD_WAIT,
        ST_PIX,
        ST_PIX_WAIT
    } state_t;

    localparam int FRAME_BYTES = 2 * WIDTH * HEIGHT;
    localparam int CNT_W       = $clog2(FRAME_BYTES + 1);

    state_t           state;
    logic [CNT_W-1:0] byte_cnt;
    logic [CNT_W-1:0] cnt_next;
    pixel_t           color_q;

    assign cnt_next = byte_cnt + 1'b1;

    always_ff @(posedge LCD_CLK or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_CMD;
            byte_cnt <= '0;
            req      <= 1'b0;
            start    <= 1'b0;
        end else begin
            req   <= 1'b1;
            start <= 1'b0;
            case (state)
                ST_CMD: begin
                    if (grant) begin
                        start    <= 1'b1;
                        byte_cnt <= '0;
                        state    <= ST_CMD_WAIT;
                    end
                end
                ST_CMD_WAIT: begin
                    if (done) begin
                        state <= ST_PIX;
                    end
                end
                ST_PIX: begin
                    if (grant) begin
                        start <= 1'b1;
                        state <= ST_PIX_WAIT;
                    end
                end
                ST_PIX_WAIT: begin
                    if (done) begin
                        if (cnt_next == CNT_W'(FRAME_BYTES)) begin
                            byte_cnt <= '0;
                            state    <= ST_CMD;
                        end else begin
                            byte_cnt <= cnt_next;
                            state    <= ST_PIX;
                        end
                    end
                end
                default: begin
                    state <= ST_CMD;
                end
            endcase
        end
    end

    // colour is frozen for the whole frame once RAMWR goes out
    always_ff @(posedge LCD_CLK) begin
        if (state == ST_CMD) begin
            color_q  <= fill_color;
            byte_out <= CMD_RAMWR;
            dc       <= 1'b0;
        end else if (state == ST_PIX) begin
            byte_out <= byte_cnt[0] ? color_q[7:0] : color_q[15:8];
            dc       <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- init_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module init_sequencer #(
    parameter int WIDTH        = lcd_pkg::DEFAULT_WIDTH,
    parameter int HEIGHT       = lcd_pkg::DEFAULT_HEIGHT,
    parameter int DELAY_CYCLES = lcd_pkg::DEFAULT_DELAY_CYCLES
) (
    input  logic           LCD_CLK,
    input  logic           arst_n,
    input  logic           grant,
    input  logic           done,
    output logic           req,
    output lcd_pkg::byte_t byte_out,
    output logic           dc,
    output logic           start,
    output logic           lcd_rst
);
    import lcd_pkg::*;

    typedef enum logic [2:0] {
        ST_RST_LOW,
        ST_WAKE,
        ST_FETCH,
        ST_SEND,
        ST_WAIT,
        ST_DONE
    } state_t;

    state_t             state;
    rom_addr_t          addr;
    rom_entry_t         entry;
    rom_kind_t          kind;
    logic [DELAY_W-1:0] delay_cnt;
    logic               delay_end;

    init_rom #(
        .WIDTH (WIDTH),
        .HEIGHT(HEIGHT)
    ) u_rom (
        .addr (addr),
        .entry(entry)
    );

    assign kind      = entry[9:8];
    assign delay_end = (delay_cnt == DELAY_W'(DELAY_CYCLES - 1));

    always_ff @(posedge LCD_CLK or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_RST_LOW;
            addr      <= '0;
            delay_cnt <= '0;
            req       <= 1'b0;
            start     <= 1'b0;
            lcd_rst   <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                ST_RST_LOW: begin
                    req <= 1'b1;
                    if (delay_end) begin
                        delay_cnt <= '0;
                        lcd_rst   <= 1'b1;
                        state     <= ST_WAKE;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                // panel needs time after the reset pin rises
                ST_WAKE: begin
                    if (delay_end) begin
                        delay_cnt <= '0;
                        state     <= ST_FETCH;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                ST_FETCH: begin
                    if (kind == KIND_END) begin
                        req   <= 1'b0;
                        state <= ST_DONE;
                    end else if (kind == KIND_WAIT) begin
                        state <= ST_WAIT;
                    end else if (grant) begin
                        start <= 1'b1;
                        state <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (done) begin
                        addr  <= addr + 1'b1;
                        state <= ST_FETCH;
                    end
                end
                ST_WAIT: begin
                    if (delay_end) begin
                        delay_cnt <= '0;
                        addr      <= addr + 1'b1;
                        state     <= ST_FETCH;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                ST_DONE: begin
                    state <= ST_DONE;
                end
                default: begin
                    state <= ST_RST_LOW;
                end
            endcase
        end
    end

    // byte and flag follow the entry under fetch
    always_ff @(posedge LCD_CLK) begin
        if (state == ST_FETCH) begin
            byte_out <= entry[7:0];
            dc       <= (kind == KIND_DATA);
        end
    end

endmodule

`default_nettype wire

//--- init_rom.sv
`timescale 1ns/1ps
`default_nettype none

module init_rom #(
    parameter int WIDTH  = lcd_pkg::DEFAULT_WIDTH,
    parameter int HEIGHT = lcd_pkg::DEFAULT_HEIGHT
) (
    input  lcd_pkg::rom_addr_t  addr,
    output lcd_pkg::rom_entry_t entry
);
    import lcd_pkg::*;

    byte_t col_end;
    byte_t row_end;

    // window covers the whole panel
    assign col_end = byte_t'(WIDTH - 1);
    assign row_end = byte_t'(HEIGHT - 1);

    always_comb begin
        entry = {KIND_END, 8'h00};
        if (addr < INIT_LEN) begin
            case (addr)
                5'd0:  entry = {KIND_CMD, CMD_SLPOUT};
                5'd1:  entry = {KIND_WAIT, 8'h00};
                5'd2:  entry = {KIND_CMD, CMD_COLMOD};
                5'd3:  entry = {KIND_DATA, COLMOD_16BIT};
                5'd4:  entry = {KIND_CMD, CMD_MADCTL};
                5'd5:  entry = {KIND_DATA, MADCTL_DEFAULT};
                5'd6:  entry = {KIND_CMD, CMD_INVON};
                5'd7:  entry = {KIND_CMD, CMD_CASET};
                5'd8:  entry = {KIND_DATA, 8'h00};
                5'd9:  entry = {KIND_DATA, 8'h00};
                5'd10: entry = {KIND_DATA, 8'h00};
                5'd11: entry = {KIND_DATA, col_end};
                5'd12: entry = {KIND_CMD, CMD_RASET};
                5'd13: entry = {KIND_DATA, 8'h00};
                5'd14: entry = {KIND_DATA, 8'h00};
                5'd15: entry = {KIND_DATA, 8'h00};
                5'd16: entry = {KIND_DATA, row_end};
                5'd17: entry = {KIND_CMD, CMD_DISPON};
                5'd18: entry = {KIND_END, 8'h00};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // serial link payload
    typedef logic [7:0]  byte_t;
    // rgb565
    typedef logic [15:0] pixel_t;

    // init table entry is {kind, byte}
    typedef logic [9:0]  rom_entry_t;
    typedef logic [1:0]  rom_kind_t;
    typedef logic [4:0]  rom_addr_t;

    localparam rom_kind_t KIND_CMD  = 2'd0;
    localparam rom_kind_t KIND_DATA = 2'd1;
    localparam rom_kind_t KIND_WAIT = 2'd2;
    localparam rom_kind_t KIND_END  = 2'd3;

    // slots in the table, the tail past the last command reads as END
    localparam int INIT_LEN = 20;

    // st7735 command set in use
    localparam byte_t CMD_SLPOUT = 8'h11;
    localparam byte_t CMD_INVON  = 8'h21;
    localparam byte_t CMD_DISPON = 8'h29;
    localparam byte_t CMD_CASET  = 8'h2A;
    localparam byte_t CMD_RASET  = 8'h2B;
    localparam byte_t CMD_RAMWR  = 8'h2C;
    localparam byte_t CMD_MADCTL = 8'h36;
    localparam byte_t CMD_COLMOD = 8'h3A;

    localparam byte_t COLMOD_16BIT   = 8'h05;
    localparam byte_t MADCTL_DEFAULT = 8'h00;

    localparam int DEFAULT_WIDTH  = 160;
    localparam int DEFAULT_HEIGHT = 120;

    // 100 ms at 12 MHz
    localparam int DEFAULT_DELAY_CYCLES = 1_200_000;
    localparam int DELAY_W = 21;

    // sck low then high, one system cycle each
    localparam int BIT_CYCLES = 2;

endpackage

`default_nettype wire
